//--- verilog/isp_video_pkg.sv
package isp_video_pkg;

    // frame geometry, kept small for whole-frame simulation
    localparam int PIX_WIDTH  = 10;
    localparam int IMG_WIDTH  = 16;
    localparam int IMG_HEIGHT = 8;

    typedef logic [PIX_WIDTH-1:0]           pix_t;
    typedef logic [$clog2(IMG_WIDTH)-1:0]   col_t;
    typedef logic [$clog2(IMG_HEIGHT)-1:0]  row_t;

    // weighted sum of nine pixels, weights up to 16 in total
    typedef logic [PIX_WIDTH+3:0]           sum_t;

    // one stream beat
    typedef struct packed {
        pix_t data;
        logic user;
        logic last;
        logic valid;
    } pix_beat_t;

    // pRC is row R, column C; p22 is the newest pixel
    typedef struct packed {
        pix_t p00;
        pix_t p01;
        pix_t p02;
        pix_t p10;
        pix_t p11;
        pix_t p12;
        pix_t p20;
        pix_t p21;
        pix_t p22;
        logic user;
        logic last;
        logic valid;
    } win3x3_t;

endpackage

//--- verilog/isp_ctrl_pkg.sv
package isp_ctrl_pkg;

    import isp_video_pkg::*;

    // correction threshold in pixel units
    typedef logic [PIX_WIDTH-1:0] thresh_t;

    // per-stage controls, sampled once at the top
    typedef struct packed {
        logic    dpc_en;
        thresh_t dpc_threshold;
        logic    gauss_en;
    } isp_cfg_t;

endpackage

//--- verilog/isp_window_3x3.sv
`timescale 1ns/1ps

module isp_window_3x3
    import isp_video_pkg::*;
(
    input  logic      pixel_clk,
    input  logic      rst_n,
    input  logic      adv,
    input  pix_beat_t pix_in,
    output win3x3_t   win_out
);

    // previous two rows, line_buf1 is row r-1
    pix_t line_buf1 [IMG_WIDTH];
    pix_t line_buf2 [IMG_WIDTH];

    col_t col_cnt;
    row_t row_cnt;
    col_t cur_col;
    row_t cur_row;

    // incoming column, top to bottom
    pix_t col_new [3];

    // registered window, [row][col]
    pix_t tap [3][3];
    logic win_valid;
    logic win_user;
    logic win_last;

    // start of frame forces position zero for this beat
    assign cur_col = pix_in.user ? '0 : col_cnt;
    assign cur_row = pix_in.user ? '0 : row_cnt;

    // rows above the frame read zero
    always_comb
    begin
        col_new[0] = (cur_row >= row_t'(2)) ? line_buf2[cur_col] : '0;
        col_new[1] = (cur_row >= row_t'(1)) ? line_buf1[cur_col] : '0;
        col_new[2] = pix_in.data;
    end

    always_ff @(posedge pixel_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
        end
        else if (adv)
        begin
            win_valid <= pix_in.valid;
            if (pix_in.valid)
            begin
                if (pix_in.last)
                begin
                    col_cnt <= '0;
                    row_cnt <= cur_row + row_t'(1);
                end
                else
                begin
                    col_cnt <= cur_col + col_t'(1);
                    row_cnt <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (adv)
        begin
            win_user <= pix_in.user;
            win_last <= pix_in.last;
            if (pix_in.valid)
            begin
                line_buf2[cur_col] <= line_buf1[cur_col];
                line_buf1[cur_col] <= pix_in.data;
                // columns left of the frame read zero
                for (int r = 0; r < 3; r++)
                begin
                    tap[r][0] <= (cur_col >= col_t'(2)) ? tap[r][1] : '0;
                    tap[r][1] <= (cur_col >= col_t'(1)) ? tap[r][2] : '0;
                    tap[r][2] <= col_new[r];
                end
            end
        end
    end

    always_comb
    begin
        win_out.p00   = tap[0][0];
        win_out.p01   = tap[0][1];
        win_out.p02   = tap[0][2];
        win_out.p10   = tap[1][0];
        win_out.p11   = tap[1][1];
        win_out.p12   = tap[1][2];
        win_out.p20   = tap[2][0];
        win_out.p21   = tap[2][1];
        win_out.p22   = tap[2][2];
        win_out.user  = win_user;
        win_out.last  = win_last;
        win_out.valid = win_valid;
    end

endmodule

//--- verilog/isp_dpc.sv
`timescale 1ns/1ps

module isp_dpc
    import isp_video_pkg::*;
    import isp_ctrl_pkg::*;
(
    input  logic      pixel_clk,
    input  logic      rst_n,
    input  logic      adv,
    input  isp_cfg_t  cfg,
    input  win3x3_t   win_in,
    output pix_beat_t pix_out
);

    pix_t nb [8];
    pix_t nb_min;
    pix_t nb_max;
    sum_t orth_sum;

    // stage one
    pix_t s1_min;
    pix_t s1_max;
    pix_t s1_mean;
    pix_t s1_centre;
    logic s1_user;
    logic s1_last;
    logic s1_valid;

    // stage two
    logic [PIX_WIDTH:0] hi_limit;
    logic [PIX_WIDTH:0] lo_check;
    logic is_hot;
    logic is_cold;
    pix_t out_data;
    logic out_user;
    logic out_last;
    logic out_valid;

    // range of the eight neighbours around p11
    always_comb
    begin
        nb[0] = win_in.p00;
        nb[1] = win_in.p01;
        nb[2] = win_in.p02;
        nb[3] = win_in.p10;
        nb[4] = win_in.p12;
        nb[5] = win_in.p20;
        nb[6] = win_in.p21;
        nb[7] = win_in.p22;
        nb_min = nb[0];
        nb_max = nb[0];
        for (int i = 1; i < 8; i++)
        begin
            if (nb[i] < nb_min)
                nb_min = nb[i];
            if (nb[i] > nb_max)
                nb_max = nb[i];
        end
    end

    assign orth_sum = sum_t'(win_in.p01) + sum_t'(win_in.p10)
                    + sum_t'(win_in.p12) + sum_t'(win_in.p21);

    // one extra bit so threshold addition cannot wrap
    assign hi_limit = {1'b0, s1_max} + {1'b0, cfg.dpc_threshold};
    assign lo_check = {1'b0, s1_centre} + {1'b0, cfg.dpc_threshold};
    assign is_hot   = {1'b0, s1_centre} > hi_limit;
    assign is_cold  = lo_check < {1'b0, s1_min};

    always_ff @(posedge pixel_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else if (adv)
        begin
            s1_valid  <= win_in.valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (adv)
        begin
            s1_min    <= nb_min;
            s1_max    <= nb_max;
            s1_mean   <= orth_sum[PIX_WIDTH+1:2];
            s1_centre <= win_in.p11;
            s1_user   <= win_in.user;
            s1_last   <= win_in.last;

            out_data  <= (cfg.dpc_en && (is_hot || is_cold)) ? s1_mean : s1_centre;
            out_user  <= s1_user;
            out_last  <= s1_last;
        end
    end

    assign pix_out = '{data: out_data, user: out_user, last: out_last, valid: out_valid};

endmodule

//--- verilog/isp_gauss.sv
`timescale 1ns/1ps

module isp_gauss
    import isp_video_pkg::*;
    import isp_ctrl_pkg::*;
(
    input  logic      pixel_clk,
    input  logic      rst_n,
    input  logic      adv,
    input  isp_cfg_t  cfg,
    input  win3x3_t   win_in,
    output pix_beat_t pix_out
);

    // stage one, horizontal 1-2-1 per row
    sum_t row0_sum;
    sum_t row1_sum;
    sum_t row2_sum;
    pix_t s1_centre;
    logic s1_user;
    logic s1_last;
    logic s1_valid;

    // stage two, vertical 1-2-1
    sum_t total;
    pix_t out_data;
    logic out_user;
    logic out_last;
    logic out_valid;

    // full-scale window gives 16 * 1023, fits sum_t
    assign total = row0_sum + (row1_sum << 1) + row2_sum;

    always_ff @(posedge pixel_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else if (adv)
        begin
            s1_valid  <= win_in.valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (adv)
        begin
            row0_sum  <= sum_t'(win_in.p00) + (sum_t'(win_in.p01) << 1) + sum_t'(win_in.p02);
            row1_sum  <= sum_t'(win_in.p10) + (sum_t'(win_in.p11) << 1) + sum_t'(win_in.p12);
            row2_sum  <= sum_t'(win_in.p20) + (sum_t'(win_in.p21) << 1) + sum_t'(win_in.p22);
            s1_centre <= win_in.p11;
            s1_user   <= win_in.user;
            s1_last   <= win_in.last;

            // divide by sixteen, truncating
            out_data  <= cfg.gauss_en ? total[PIX_WIDTH+3:4] : s1_centre;
            out_user  <= s1_user;
            out_last  <= s1_last;
        end
    end

    assign pix_out = '{data: out_data, user: out_user, last: out_last, valid: out_valid};

endmodule

//--- verilog/isp_top.sv
`timescale 1ns/1ps

module isp_top
    import isp_video_pkg::*;
    import isp_ctrl_pkg::*;
(
    input  logic    pixel_clk,
    input  logic    rst_n,
    input  pix_t    s_axis_tdata,
    input  logic    s_axis_tuser,
    input  logic    s_axis_tlast,
    input  logic    s_axis_tvalid,
    output logic    s_axis_tready,
    output pix_t    m_axis_tdata,
    output logic    m_axis_tuser,
    output logic    m_axis_tlast,
    output logic    m_axis_tvalid,
    input  logic    m_axis_tready,
    input  logic    dpc_en,
    input  thresh_t dpc_threshold,
    input  logic    gauss_en
);

    logic      adv;
    isp_cfg_t  cfg;
    pix_t      in_data;
    logic      in_user;
    logic      in_last;
    logic      in_valid;
    pix_beat_t in_beat;
    win3x3_t   dpc_win;
    pix_beat_t dpc_beat;
    win3x3_t   gauss_win;
    pix_beat_t gauss_beat;

    // whole pipeline moves only when the sink takes a beat
    assign adv           = m_axis_tready;
    assign s_axis_tready = m_axis_tready;

    // config sampled every clock
    always_ff @(posedge pixel_clk or negedge rst_n)
    begin
        if (!rst_n)
            cfg <= '0;
        else
            cfg <= '{dpc_en: dpc_en, dpc_threshold: dpc_threshold, gauss_en: gauss_en};
    end

    always_ff @(posedge pixel_clk or negedge rst_n)
    begin
        if (!rst_n)
            in_valid <= 1'b0;
        else if (adv)
            in_valid <= s_axis_tvalid;
    end

    always_ff @(posedge pixel_clk)
    begin
        if (adv)
        begin
            in_data <= s_axis_tdata;
            in_user <= s_axis_tuser;
            in_last <= s_axis_tlast;
        end
    end

    assign in_beat = '{data: in_data, user: in_user, last: in_last, valid: in_valid};

    isp_window_3x3 u_dpc_window (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .adv       (adv),
        .pix_in    (in_beat),
        .win_out   (dpc_win)
    );

    isp_dpc u_dpc (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .adv       (adv),
        .cfg       (cfg),
        .win_in    (dpc_win),
        .pix_out   (dpc_beat)
    );

    isp_window_3x3 u_gauss_window (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .adv       (adv),
        .pix_in    (dpc_beat),
        .win_out   (gauss_win)
    );

    isp_gauss u_gauss (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .adv       (adv),
        .cfg       (cfg),
        .win_in    (gauss_win),
        .pix_out   (gauss_beat)
    );

    assign m_axis_tdata  = gauss_beat.data;
    assign m_axis_tuser  = gauss_beat.user;
    assign m_axis_tlast  = gauss_beat.last;
    assign m_axis_tvalid = gauss_beat.valid;

endmodule

//--- testbench/tb_isp_ref.svh
`ifndef TB_ISP_REF_SVH
`define TB_ISP_REF_SVH

// raw frame, corrected frame, smoothed frame
pix_t ref_in  [IMG_HEIGHT][IMG_WIDTH];
pix_t ref_mid [IMG_HEIGHT][IMG_WIDTH];
pix_t ref_out [IMG_HEIGHT][IMG_WIDTH];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// zero outside the frame, sel 0 reads the raw frame
function automatic int ref_tap(input int sel, input int r, input int c);
    if (r < 0 || c < 0)
        return 0;
    if (sel == 0)
        return int'(ref_in[r][c]);
    return int'(ref_mid[r][c]);
endfunction

// window anchored on the newest pixel, centre is (r-1, c-1)
function automatic pix_t correct_pixel(input int r, input int c, input logic en, input int th);
    int w [3][3];
    int lo;
    int hi;
    int mean;
    for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
            w[i][j] = ref_tap(0, r - 2 + i, c - 2 + j);
    lo = 1 << PIX_WIDTH;
    hi = -1;
    for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
            if (!(i == 1 && j == 1))
            begin
                if (w[i][j] < lo)
                    lo = w[i][j];
                if (w[i][j] > hi)
                    hi = w[i][j];
            end
    mean = (w[0][1] + w[1][0] + w[1][2] + w[2][1]) / 4;
    if (en && ((w[1][1] > hi + th) || (w[1][1] + th < lo)))
        return pix_t'(mean);
    return pix_t'(w[1][1]);
endfunction

function automatic pix_t smooth_pixel(input int r, input int c, input logic en);
    int wt [3];
    int total;
    wt[0] = 1;
    wt[1] = 2;
    wt[2] = 1;
    total = 0;
    for (int i = 0; i < 3; i++)
        for (int j = 0; j < 3; j++)
            total += wt[i] * wt[j] * ref_tap(1, r - 2 + i, c - 2 + j);
    if (!en)
        return pix_t'(ref_tap(1, r - 1, c - 1));
    return pix_t'(total / 16);
endfunction

// correction first, then smoothing over the corrected frame
function automatic void compute_reference(input logic dpc_on, input int th, input logic gauss_on);
    for (int r = 0; r < IMG_HEIGHT; r++)
        for (int c = 0; c < IMG_WIDTH; c++)
            ref_mid[r][c] = correct_pixel(r, c, dpc_on, th);
    for (int r = 0; r < IMG_HEIGHT; r++)
        for (int c = 0; c < IMG_WIDTH; c++)
            ref_out[r][c] = smooth_pixel(r, c, gauss_on);
endfunction

`endif

//--- testbench/tb_isp_top.sv
`timescale 1ns/1ps

module tb_isp_top
    import isp_video_pkg::*;
    import isp_ctrl_pkg::*;
;

    localparam logic [31:0] SEED = 32'h30581021;
    localparam int NUM_FRAMES     = 7;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * IMG_WIDTH * IMG_HEIGHT * 8 + 200;

    logic    pixel_clk;
    logic    rst_n;
    pix_t    s_axis_tdata;
    logic    s_axis_tuser;
    logic    s_axis_tlast;
    logic    s_axis_tvalid;
    logic    s_axis_tready;
    pix_t    m_axis_tdata;
    logic    m_axis_tuser;
    logic    m_axis_tlast;
    logic    m_axis_tvalid;
    logic    m_axis_tready;
    logic    dpc_en;
    thresh_t dpc_threshold;
    logic    gauss_en;

    logic [31:0] stim_rng;
    logic [31:0] ready_rng;
    int          ready_level;
    int          gap_level;
    int          cycle_count;
    pix_beat_t   exp_q [$];
    pix_beat_t   exp_beat;

    `include "tb_isp_ref.svh"

    isp_top dut (
        .pixel_clk     (pixel_clk),
        .rst_n         (rst_n),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .dpc_en        (dpc_en),
        .dpc_threshold (dpc_threshold),
        .gauss_en      (gauss_en)
    );

    initial
    begin
        pixel_clk = 1'b0;
        forever #4 pixel_clk = ~pixel_clk;
    end

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name,
                     expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // entered and left on a falling edge
    task automatic send_beat(input pix_t pix, input logic user, input logic last);
        while ((next_rand() & 32'h7) < gap_level)
        begin
            s_axis_tvalid = 1'b0;
            @(negedge pixel_clk);
        end
        s_axis_tdata  = pix;
        s_axis_tuser  = user;
        s_axis_tlast  = last;
        s_axis_tvalid = 1'b1;
        @(posedge pixel_clk);
        while (!s_axis_tready)
            @(posedge pixel_clk);
        @(negedge pixel_clk);
    endtask

    task automatic send_frame();
        logic [31:0] rnd;
        pix_beat_t   beat;
        for (int r = 0; r < IMG_HEIGHT; r++)
            for (int c = 0; c < IMG_WIDTH; c++)
            begin
                rnd = next_rand();
                // about one in eight stuck at full scale or zero
                if (rnd[2:0] == 3'd0)
                    ref_in[r][c] = rnd[3] ? '1 : '0;
                else
                    ref_in[r][c] = pix_t'(384 + rnd[15:8]);
            end
        compute_reference(dpc_en, int'(dpc_threshold), gauss_en);
        for (int r = 0; r < IMG_HEIGHT; r++)
            for (int c = 0; c < IMG_WIDTH; c++)
            begin
                beat.data  = ref_out[r][c];
                beat.user  = (r == 0 && c == 0);
                beat.last  = (c == IMG_WIDTH - 1);
                beat.valid = 1'b1;
                exp_q.push_back(beat);
            end
        for (int r = 0; r < IMG_HEIGHT; r++)
            for (int c = 0; c < IMG_WIDTH; c++)
                send_beat(ref_in[r][c], r == 0 && c == 0, c == IMG_WIDTH - 1);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic run_phase(input logic dpc_on, input thresh_t th, input logic gauss_on,
                             input int frames, input int rlevel, input int glevel);
        dpc_en        = dpc_on;
        dpc_threshold = th;
        gauss_en      = gauss_on;
        ready_level   = rlevel;
        gap_level     = glevel;
        repeat (2) @(negedge pixel_clk);
        repeat (frames) send_frame();
        // drain before the next configuration
        while (exp_q.size() != 0)
            @(negedge pixel_clk);
        repeat (4) @(negedge pixel_clk);
    endtask

    // sink back-pressure on its own random stream
    initial
    begin
        ready_rng = ~SEED;
        forever
        begin
            @(negedge pixel_clk);
            ready_rng     = xorshift32(ready_rng);
            m_axis_tready = (ready_rng[2:0] >= ready_level);
        end
    end

    always @(posedge pixel_clk)
    begin
        if (rst_n)
        begin
            check_value("s_axis_tready", s_axis_tready, m_axis_tready);
            if (m_axis_tvalid && m_axis_tready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Output beat at %0t with no expected beat left", $time);
                    $display("TEST FAILED");
                    $fatal(1);
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    check_value("m_axis_tdata", m_axis_tdata, exp_beat.data);
                    check_value("m_axis_tuser", m_axis_tuser, exp_beat.user);
                    check_value("m_axis_tlast", m_axis_tlast, exp_beat.last);
                end
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge pixel_clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES)
            begin
                $display("Timeout after %0d cycles, %0d output beats never arrived",
                         cycle_count, exp_q.size());
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    end

    initial
    begin
        stim_rng      = SEED;
        rst_n         = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tuser  = 1'b0;
        s_axis_tlast  = 1'b0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        dpc_en        = 1'b0;
        dpc_threshold = '0;
        gauss_en      = 1'b0;
        ready_level   = 0;
        gap_level     = 0;
        repeat (5) @(posedge pixel_clk);
        check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
        @(negedge pixel_clk);
        rst_n = 1'b1;
        @(negedge pixel_clk);
        check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);

        // plain delay, correction only, smoothing only
        run_phase(1'b0, thresh_t'(0), 1'b0, 1, 0, 0);
        run_phase(1'b1, thresh_t'(40), 1'b0, 1, 2, 1);
        run_phase(1'b0, thresh_t'(0), 1'b1, 1, 0, 2);
        // both stages over back to back frames
        run_phase(1'b1, thresh_t'(90), 1'b1, 2, 3, 2);
        // heavy back-pressure and input gaps
        run_phase(1'b1, thresh_t'(25), 1'b1, 2, 4, 4);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
verilog/isp_video_pkg.sv
verilog/isp_ctrl_pkg.sv
verilog/isp_window_3x3.sv
verilog/isp_dpc.sv
verilog/isp_gauss.sv
verilog/isp_top.sv
testbench/tb_isp_top.sv
